// File: common/icache_pkg.sv
package icache_pkg;

   ////////////////////////////////////////
   // Address and data widths
   ////////////////////////////////////////

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int LINE_WORDS = 8;
   localparam int OFF_W      = 3;
   localparam int LINE_W     = LINE_WORDS * DATA_W;

   ////////////////////////////////////////
   // AXI4 read burst constants
   ////////////////////////////////////////

   // Single fixed ID, no reordering needed
   localparam logic [3:0] AXI_ID = 4'b1111;

   // Eight beats per line
   localparam logic [7:0] AXI_LEN = 8'd7;

   // Four bytes per beat
   localparam logic [2:0] AXI_SIZE_WORD = 3'b010;

   // Wrapping burst, critical word first
   localparam logic [1:0] AXI_BURST_WRAP = 2'b10;

   ////////////////////////////////////////
   // Refill FSM states
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ADDR,
      ST_DATA,
      ST_WRITE
   } refill_state_t;

endpackage

// File: design/icache_lookup/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup import icache_pkg::*; #(
   parameter int SET_W = 7
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              i_req_valid,
   input  logic [ADDR_W-1:0] i_req_addr,
   input  logic              i_refill_busy,
   input  logic              i_rsp_pending,
   input  logic              i_line_we,
   input  logic [ADDR_W-1:0] i_line_addr,
   input  logic              i_line_way,
   output logic              o_req_ready,
   output logic              o_accept,
   output logic              o_hit,
   output logic              o_miss,
   output logic              o_way,
   output logic [ADDR_W-1:0] o_addr
);

   localparam int TAG_W = ADDR_W - SET_W - OFF_W - 2;
   localparam int SETS  = 1 << SET_W;
   localparam int SET_LO = OFF_W + 2;

   // Tag store, one entry per set and way
   logic [TAG_W-1:0] tag_mem [2][SETS];
   logic [1:0]       valid_q [SETS];
   logic [SETS-1:0]  lru_q;

   // Request held in the lookup stage
   logic              pend_q;
   logic [ADDR_W-1:0] addr_q;
   logic [TAG_W-1:0]  rd_tag0_q;
   logic [TAG_W-1:0]  rd_tag1_q;
   logic [1:0]        rd_valid_q;
   logic              rd_lru_q;

   logic [SET_W-1:0] req_set;
   logic [SET_W-1:0] cur_set;
   logic [TAG_W-1:0] cur_tag;
   logic [SET_W-1:0] line_set;
   logic [TAG_W-1:0] line_tag;
   logic             hit0;
   logic             hit1;

   assign req_set  = i_req_addr[SET_LO+SET_W-1:SET_LO];
   assign cur_set  = addr_q[SET_LO+SET_W-1:SET_LO];
   assign cur_tag  = addr_q[ADDR_W-1:ADDR_W-TAG_W];
   assign line_set = i_line_addr[SET_LO+SET_W-1:SET_LO];
   assign line_tag = i_line_addr[ADDR_W-1:ADDR_W-TAG_W];

   ////////////////////////////////////////
   // Request acceptance
   ////////////////////////////////////////

   // No new fetch while a lookup, refill or response is in flight
   assign o_req_ready = !pend_q && !i_refill_busy && !i_rsp_pending;
   assign o_accept    = i_req_valid && o_req_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         pend_q <= 1'b0;
      end else begin
         pend_q <= o_accept;
      end
   end

   // Capture the address and the set contents at accept
   always_ff @(posedge clk) begin
      if (o_accept) begin
         addr_q     <= i_req_addr;
         rd_tag0_q  <= tag_mem[0][req_set];
         rd_tag1_q  <= tag_mem[1][req_set];
         rd_valid_q <= valid_q[req_set];
         rd_lru_q   <= lru_q[req_set];
      end
   end

   ////////////////////////////////////////
   // Hit detection
   ////////////////////////////////////////

   assign hit0 = rd_valid_q[0] && (rd_tag0_q == cur_tag);
   assign hit1 = rd_valid_q[1] && (rd_tag1_q == cur_tag);

   assign o_hit  = pend_q && (hit0 || hit1);
   assign o_miss = pend_q && !(hit0 || hit1);

   // Hit way, otherwise the LRU victim
   assign o_way  = (hit0 || hit1) ? hit1 : rd_lru_q;
   assign o_addr = addr_q;

   ////////////////////////////////////////
   // Tag store update
   ////////////////////////////////////////

   // Valid and LRU bits, the LRU bit names the next victim
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < SETS; s++) begin
            valid_q[s] <= 2'b00;
         end
         lru_q <= '0;
      end else if (i_line_we) begin
         valid_q[line_set][i_line_way] <= 1'b1;
         lru_q[line_set]               <= ~i_line_way;
      end else if (o_hit) begin
         lru_q[cur_set] <= ~o_way;
      end
   end

   always_ff @(posedge clk) begin
      if (i_line_we) begin
         tag_mem[i_line_way][line_set] <= line_tag;
      end
   end

endmodule

// File: design/icache_refill/icache_refill.sv
`timescale 1ns/1ps

module icache_refill import icache_pkg::*; #(
   parameter int SET_W = 7
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              i_miss,
   input  logic [ADDR_W-1:0] i_addr,
   input  logic              i_way,
   input  logic              i_arready,
   input  logic              i_rvalid,
   input  logic [DATA_W-1:0] i_rdata,
   input  logic              i_rlast,
   output logic              o_busy,
   output logic              o_arvalid,
   output logic [ADDR_W-1:0] o_araddr,
   output logic [3:0]        o_arid,
   output logic [7:0]        o_arlen,
   output logic [2:0]        o_arsize,
   output logic [1:0]        o_arburst,
   output logic              o_rready,
   output logic              o_crit_valid,
   output logic [DATA_W-1:0] o_crit_data,
   output logic              o_line_we,
   output logic [ADDR_W-1:0] o_line_addr,
   output logic              o_line_way,
   output logic [LINE_W-1:0] o_line_data
);

   // Word offset sits just above the two byte bits
   localparam int SET_LO = OFF_W + 2;

   refill_state_t state_q;

   logic                               first_q;
   logic [ADDR_W-1:0]                  addr_q;
   logic                               way_q;
   logic [OFF_W-1:0]                   cnt_q;
   logic [LINE_WORDS-1:0][DATA_W-1:0] fill_q;

   logic beat;

   assign beat = (state_q == ST_DATA) && i_rvalid;

   ////////////////////////////////////////
   // Refill FSM
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= ST_IDLE;
         first_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (i_miss) begin
                  state_q <= ST_ADDR;
                  first_q <= 1'b1;
               end
            end
            ST_ADDR: begin
               if (i_arready) begin
                  state_q <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (beat) begin
                  first_q <= 1'b0;
                  if (i_rlast) begin
                     state_q <= ST_WRITE;
                  end
               end
            end
            ST_WRITE: begin
               state_q <= ST_IDLE;
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Miss capture and fill buffer
   ////////////////////////////////////////

   // Burst starts at the requested word, so the counter starts there too
   always_ff @(posedge clk) begin
      if ((state_q == ST_IDLE) && i_miss) begin
         addr_q <= {i_addr[ADDR_W-1:2], 2'b00};
         way_q  <= i_way;
         cnt_q  <= i_addr[SET_LO-1:2];
      end else if (beat) begin
         fill_q[cnt_q] <= i_rdata;
         // Three bit counter wraps with the burst
         cnt_q         <= cnt_q + 1'b1;
      end
   end

   ////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////

   assign o_busy = (state_q != ST_IDLE) || i_miss;

   assign o_arvalid = (state_q == ST_ADDR);
   assign o_araddr  = addr_q;
   assign o_arid    = AXI_ID;
   assign o_arlen   = AXI_LEN;
   assign o_arsize  = AXI_SIZE_WORD;
   assign o_arburst = AXI_BURST_WRAP;
   assign o_rready  = (state_q == ST_DATA);

   // First beat of the wrap is the word the processor asked for
   assign o_crit_valid = beat && first_q;
   assign o_crit_data  = i_rdata;

   assign o_line_we   = (state_q == ST_WRITE);
   assign o_line_addr = addr_q;
   assign o_line_way  = way_q;
   assign o_line_data = fill_q;

endmodule

// File: design/icache_response/icache_data_ways.sv
`timescale 1ns/1ps

module icache_data_ways import icache_pkg::*; #(
   parameter int SET_W = 7
) (
   input  logic                   clk,
   input  logic                   i_rd_en,
   input  logic [SET_W+OFF_W-1:0] i_rd_addr,
   input  logic                   i_we,
   input  logic [SET_W-1:0]       i_wr_set,
   input  logic                   i_wr_way,
   input  logic [LINE_W-1:0]      i_wr_line,
   output logic [DATA_W-1:0]      o_rd_word0,
   output logic [DATA_W-1:0]      o_rd_word1
);

   localparam int DEPTH = 1 << (SET_W + OFF_W);

   logic [DATA_W-1:0] rd_word [2];

   genvar w;
   generate
      for (w = 0; w < 2; w++) begin : g_way
         logic [DATA_W-1:0] mem [DEPTH];

         // Whole line lands in one way in a single cycle
         always_ff @(posedge clk) begin
            if (i_we && (i_wr_way == w[0])) begin
               for (int k = 0; k < LINE_WORDS; k++) begin
                  mem[{i_wr_set, k[OFF_W-1:0]}] <= i_wr_line[k*DATA_W +: DATA_W];
               end
            end
         end

         // Synchronous read of both ways
         always_ff @(posedge clk) begin
            if (i_rd_en) begin
               rd_word[w] <= mem[i_rd_addr];
            end
         end
      end
   endgenerate

   assign o_rd_word0 = rd_word[0];
   assign o_rd_word1 = rd_word[1];

endmodule

// File: design/icache_response/icache_response.sv
`timescale 1ns/1ps

module icache_response import icache_pkg::*; #(
   parameter int SET_W = 7
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              i_accept,
   input  logic [ADDR_W-1:0] i_req_addr,
   input  logic              i_hit,
   input  logic              i_way,
   input  logic              i_crit_valid,
   input  logic [DATA_W-1:0] i_crit_data,
   input  logic              i_line_we,
   input  logic [ADDR_W-1:0] i_line_addr,
   input  logic              i_line_way,
   input  logic [LINE_W-1:0] i_line_data,
   input  logic              i_rsp_ready,
   output logic              o_rsp_valid,
   output logic [DATA_W-1:0] o_rsp_data,
   output logic              o_rsp_pending
);

   localparam int SET_LO = OFF_W + 2;

   logic [SET_W+OFF_W-1:0] rd_addr;
   logic [SET_W-1:0]       wr_set;
   logic [DATA_W-1:0]      word0;
   logic [DATA_W-1:0]      word1;

   logic              valid_q;
   logic [DATA_W-1:0] data_q;

   // Set and offset index the data ways directly
   assign rd_addr = i_req_addr[SET_LO+SET_W-1:2];
   assign wr_set  = i_line_addr[SET_LO+SET_W-1:SET_LO];

   icache_data_ways #(
      .SET_W (SET_W)
   ) u_ways (
      .clk        (clk),
      .i_rd_en    (i_accept),
      .i_rd_addr  (rd_addr),
      .i_we       (i_line_we),
      .i_wr_set   (wr_set),
      .i_wr_way   (i_line_way),
      .i_wr_line  (i_line_data),
      .o_rd_word0 (word0),
      .o_rd_word1 (word1)
   );

   ////////////////////////////////////////
   // Response register
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else if (i_hit || i_crit_valid) begin
         valid_q <= 1'b1;
      end else if (i_rsp_ready) begin
         valid_q <= 1'b0;
      end
   end

   // Data only moves on a new word, so it holds through a stall
   always_ff @(posedge clk) begin
      if (i_hit) begin
         data_q <= i_way ? word1 : word0;
      end else if (i_crit_valid) begin
         data_q <= i_crit_data;
      end
   end

   assign o_rsp_valid   = valid_q;
   assign o_rsp_data    = data_q;
   assign o_rsp_pending = valid_q || i_hit || i_crit_valid;

endmodule

// File: design/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
   parameter int SET_W = 7
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              i_req_valid,
   input  logic [ADDR_W-1:0] i_req_addr,
   output logic              o_req_ready,
   output logic              o_rsp_valid,
   output logic [DATA_W-1:0] o_rsp_data,
   input  logic              i_rsp_ready,
   output logic              o_arvalid,
   input  logic              i_arready,
   output logic [ADDR_W-1:0] o_araddr,
   output logic [3:0]        o_arid,
   output logic [7:0]        o_arlen,
   output logic [2:0]        o_arsize,
   output logic [1:0]        o_arburst,
   input  logic              i_rvalid,
   output logic              o_rready,
   input  logic [DATA_W-1:0] i_rdata,
   input  logic              i_rlast
);

   // Lookup stage results
   logic              accept;
   logic              hit;
   logic              miss;
   logic              way;
   logic [ADDR_W-1:0] lk_addr;

   // Refill engine results
   logic              refill_busy;
   logic              crit_valid;
   logic [DATA_W-1:0] crit_data;
   logic              line_we;
   logic [ADDR_W-1:0] line_addr;
   logic              line_way;
   logic [LINE_W-1:0] line_data;

   logic              rsp_pending;

   icache_lookup #(
      .SET_W (SET_W)
   ) u_lookup (
      .clk            (clk),
      .reset          (reset),
      .i_req_valid    (i_req_valid),
      .i_req_addr     (i_req_addr),
      .i_refill_busy  (refill_busy),
      .i_rsp_pending  (rsp_pending),
      .i_line_we      (line_we),
      .i_line_addr    (line_addr),
      .i_line_way     (line_way),
      .o_req_ready    (o_req_ready),
      .o_accept       (accept),
      .o_hit          (hit),
      .o_miss         (miss),
      .o_way          (way),
      .o_addr         (lk_addr)
   );

   icache_refill #(
      .SET_W (SET_W)
   ) u_refill (
      .clk            (clk),
      .reset          (reset),
      .i_miss         (miss),
      .i_addr         (lk_addr),
      .i_way          (way),
      .i_arready      (i_arready),
      .i_rvalid       (i_rvalid),
      .i_rdata        (i_rdata),
      .i_rlast        (i_rlast),
      .o_busy         (refill_busy),
      .o_arvalid      (o_arvalid),
      .o_araddr       (o_araddr),
      .o_arid         (o_arid),
      .o_arlen        (o_arlen),
      .o_arsize       (o_arsize),
      .o_arburst      (o_arburst),
      .o_rready       (o_rready),
      .o_crit_valid   (crit_valid),
      .o_crit_data    (crit_data),
      .o_line_we      (line_we),
      .o_line_addr    (line_addr),
      .o_line_way     (line_way),
      .o_line_data    (line_data)
   );

   icache_response #(
      .SET_W (SET_W)
   ) u_response (
      .clk            (clk),
      .reset          (reset),
      .i_accept       (accept),
      .i_req_addr     (i_req_addr),
      .i_hit          (hit),
      .i_way          (way),
      .i_crit_valid   (crit_valid),
      .i_crit_data    (crit_data),
      .i_line_we      (line_we),
      .i_line_addr    (line_addr),
      .i_line_way     (line_way),
      .i_line_data    (line_data),
      .i_rsp_ready    (i_rsp_ready),
      .o_rsp_valid    (o_rsp_valid),
      .o_rsp_data     (o_rsp_data),
      .o_rsp_pending  (rsp_pending)
   );

endmodule

// File: verification/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model import icache_pkg::*; #(
   parameter logic [31:0] SEED = 32'h0000_0001
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              i_arvalid,
   input  logic [ADDR_W-1:0] i_araddr,
   input  logic [7:0]        i_arlen,
   input  logic [1:0]        i_arburst,
   output logic              o_arready,
   output logic              o_rvalid,
   input  logic              i_rready,
   output logic [DATA_W-1:0] o_rdata,
   output logic              o_rlast,
   output int                o_ar_count,
   output logic [ADDR_W-1:0] o_last_araddr,
   output logic [7:0]        o_last_arlen,
   output logic [1:0]        o_last_arburst
);

   logic [ADDR_W-1:0] start_q;
   int                beat_q;
   int                burst_len_q;
   logic              active_q;
   logic              ar_fire;
   logic              r_fire;

   // Memory contents, upper half of the address inverted
   function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
      return {~addr[31:16], addr[15:0]};
   endfunction

   // Wrap boundary is the total burst size in bytes
   function automatic logic [ADDR_W-1:0] beat_addr(input logic [ADDR_W-1:0] start,
                                                   input int beat, input int len);
      logic [ADDR_W-1:0] mask;
      mask = 32'(len * 4 - 1);
      return (start & ~mask) | ((start + 32'(beat * 4)) & mask);
   endfunction

   ////////////////////////////////////////
   // Slave behaviour, driven on falling edges
   ////////////////////////////////////////

   initial begin
      void'($urandom(SEED));
      o_arready      = 1'b0;
      o_rvalid       = 1'b0;
      o_rdata        = '0;
      o_rlast        = 1'b0;
      o_ar_count     = 0;
      o_last_araddr  = '0;
      o_last_arlen   = '0;
      o_last_arburst = '0;
      start_q        = '0;
      beat_q         = 0;
      burst_len_q    = 1;
      active_q       = 1'b0;
      ar_fire        = 1'b0;
      r_fire         = 1'b0;
      forever begin
         @(negedge clk);
         if (reset) begin
            o_arready = 1'b0;
            o_rvalid  = 1'b0;
            o_rlast   = 1'b0;
            active_q  = 1'b0;
            ar_fire   = 1'b0;
            r_fire    = 1'b0;
         end else begin
            // Handshakes that completed on the last rising edge
            if (r_fire) begin
               beat_q = beat_q + 1;
               if (beat_q == burst_len_q) begin
                  active_q = 1'b0;
               end
            end
            if (ar_fire) begin
               o_ar_count     = o_ar_count + 1;
               o_last_araddr  = i_araddr;
               o_last_arlen   = i_arlen;
               o_last_arburst = i_arburst;
               start_q        = i_araddr;
               burst_len_q    = int'(i_arlen) + 1;
               beat_q         = 0;
               active_q       = 1'b1;
            end

            // R channel, a raised valid stays up until taken
            if (!active_q) begin
               o_rvalid = 1'b0;
            end else if (!o_rvalid || r_fire) begin
               o_rvalid = ($urandom % 4) != 0;
            end
            o_rdata = mem_word(beat_addr(start_q, beat_q, burst_len_q));
            o_rlast = active_q && (beat_q == burst_len_q - 1);
            r_fire  = o_rvalid && i_rready;

            // AR channel, one burst outstanding at most
            o_arready = !active_q && (($urandom % 3) != 0);
            ar_fire   = o_arready && i_arvalid;
         end
      end
   end

endmodule

// File: verification/icache_tb.sv
`timescale 1ns/1ps

module icache_tb import icache_pkg::*; ();

   localparam int CLK_PERIOD      = 10;
   localparam int NUM_TESTS       = 13;
   localparam int CYCLES_PER_TEST = 200;
   localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + 10) * CLK_PERIOD;

   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic              miss;
      logic [3:0]        stall;
   } entry_t;

   // Set 2 holds A (tag 1), B (tag 2) and C (tag 3)
   entry_t tests [NUM_TESTS] = '{
      '{32'h0000_009C, 1'b1, 4'd0},   // cold miss on the last word, wraps
      '{32'h0000_0080, 1'b0, 4'd0},
      '{32'h0000_008C, 1'b0, 4'd3},
      '{32'h0000_0098, 1'b0, 4'd0},
      '{32'h0000_1040, 1'b1, 4'd0},   // A
      '{32'h0000_2048, 1'b1, 4'd4},   // B, stalled miss
      '{32'h0000_1044, 1'b0, 4'd0},   // A
      '{32'h0000_3050, 1'b1, 4'd2},   // C evicts B
      '{32'h0000_105C, 1'b0, 4'd5},   // A
      '{32'h0000_2040, 1'b1, 4'd0},   // B again
      '{32'h0000_1058, 1'b0, 4'd0},
      '{32'hABCD_E3F4, 1'b1, 4'd1},
      '{32'hABCD_E3E0, 1'b0, 4'd2}
   };

   logic              clk;
   logic              reset;
   logic              req_valid;
   logic [ADDR_W-1:0] req_addr;
   logic              req_ready;
   logic              rsp_valid;
   logic [DATA_W-1:0] rsp_data;
   logic              rsp_ready;
   logic              arvalid;
   logic              arready;
   logic [ADDR_W-1:0] araddr;
   logic [3:0]        arid;
   logic [7:0]        arlen;
   logic [2:0]        arsize;
   logic [1:0]        arburst;
   logic              rvalid;
   logic              rready;
   logic [DATA_W-1:0] rdata;
   logic              rlast;

   int                ar_count;
   logic [ADDR_W-1:0] last_araddr;
   logic [7:0]        last_arlen;
   logic [1:0]        last_arburst;

   int   errors;
   int   responses;
   int   exp_bursts;
   logic rsp_valid_d;

   icache_top dut0 (
      .clk         (clk),
      .reset       (reset),
      .i_req_valid (req_valid),
      .i_req_addr  (req_addr),
      .o_req_ready (req_ready),
      .o_rsp_valid (rsp_valid),
      .o_rsp_data  (rsp_data),
      .i_rsp_ready (rsp_ready),
      .o_arvalid   (arvalid),
      .i_arready   (arready),
      .o_araddr    (araddr),
      .o_arid      (arid),
      .o_arlen     (arlen),
      .o_arsize    (arsize),
      .o_arburst   (arburst),
      .i_rvalid    (rvalid),
      .o_rready    (rready),
      .i_rdata     (rdata),
      .i_rlast     (rlast)
   );

   axi_mem_model #(
      .SEED (32'hd04d_b362)
   ) u_mem (
      .clk            (clk),
      .reset          (reset),
      .i_arvalid      (arvalid),
      .i_araddr       (araddr),
      .i_arlen        (arlen),
      .i_arburst      (arburst),
      .o_arready      (arready),
      .o_rvalid       (rvalid),
      .i_rready       (rready),
      .o_rdata        (rdata),
      .o_rlast        (rlast),
      .o_ar_count     (ar_count),
      .o_last_araddr  (last_araddr),
      .o_last_arlen   (last_arlen),
      .o_last_arburst (last_arburst)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Each rise of o_rsp_valid is one new response
   initial begin
      rsp_valid_d = 1'b0;
      forever begin
         @(negedge clk);
         if (rsp_valid === 1'b1 && rsp_valid_d !== 1'b1) responses = responses + 1;
         rsp_valid_d = rsp_valid;
      end
   end

   // Word at byte address A is A with the upper half inverted
   function automatic logic [DATA_W-1:0] rule_word(input logic [ADDR_W-1:0] addr);
      logic [ADDR_W-1:0] a;
      a = {addr[ADDR_W-1:2], 2'b00};
      return {~a[31:16], a[15:0]};
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors = errors + 1;
      $display("[ERROR] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
   endtask

   task automatic wait_ready();
      while (!req_ready) @(negedge clk);
   endtask

   // Fixed AR fields while an address is offered
   task automatic check_ar_fields();
      if (arid !== AXI_ID) report_mismatch("o_arid", 32'(arid), 32'(AXI_ID));
      if (arsize !== 3'b010) report_mismatch("o_arsize", 32'(arsize), 32'd2);
   endtask

   ////////////////////////////////////////
   // One table entry, fetch to response
   ////////////////////////////////////////

   task automatic run_entry(input entry_t e);
      int                ar_before;
      logic [DATA_W-1:0] exp;
      exp = rule_word(e.addr);
      wait_ready();
      ar_before = ar_count;
      req_valid = 1'b1;
      req_addr  = e.addr;
      rsp_ready = (e.stall == 4'd0);
      @(negedge clk);
      req_valid = 1'b0;
      while (!rsp_valid) begin
         @(negedge clk);
         if (arvalid === 1'b1) check_ar_fields();
      end
      if (rsp_data !== exp) report_mismatch("o_rsp_data", rsp_data, exp);
      // Stalled response must hold and block new fetches
      for (int k = 0; k < int'(e.stall); k++) begin
         @(negedge clk);
         if (rsp_valid !== 1'b1) report_mismatch("o_rsp_valid", 32'(rsp_valid), 32'd1);
         if (rsp_data !== exp) report_mismatch("o_rsp_data", rsp_data, exp);
         if (req_ready !== 1'b0) report_mismatch("o_req_ready", 32'(req_ready), 32'd0);
      end
      rsp_ready = 1'b1;
      @(negedge clk);
      rsp_ready = 1'b0;
      if (rsp_valid !== 1'b0) report_mismatch("o_rsp_valid", 32'(rsp_valid), 32'd0);
      if (ar_count - ar_before != int'(e.miss)) begin
         report_mismatch("ar_count", 32'(ar_count - ar_before), 32'(int'(e.miss)));
      end
      if (e.miss) begin
         if (last_araddr !== {e.addr[ADDR_W-1:2], 2'b00}) begin
            report_mismatch("o_araddr", last_araddr, {e.addr[ADDR_W-1:2], 2'b00});
         end
         if (last_arlen !== 8'd7) report_mismatch("o_arlen", 32'(last_arlen), 32'd7);
         if (last_arburst !== 2'b10) report_mismatch("o_arburst", 32'(last_arburst), 32'd2);
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      errors     = 0;
      responses  = 0;
      exp_bursts = 0;
      reset      = 1'b1;
      req_valid  = 1'b0;
      req_addr   = '0;
      rsp_ready  = 1'b0;
      repeat (5) @(negedge clk);
      reset = 1'b0;

      if (rsp_valid !== 1'b0) report_mismatch("o_rsp_valid", 32'(rsp_valid), 32'd0);
      if (arvalid !== 1'b0) report_mismatch("o_arvalid", 32'(arvalid), 32'd0);
      if (rready !== 1'b0) report_mismatch("o_rready", 32'(rready), 32'd0);
      if (req_ready !== 1'b1) report_mismatch("o_req_ready", 32'(req_ready), 32'd1);

      for (int i = 0; i < NUM_TESTS; i++) begin
         if (tests[i].miss) exp_bursts = exp_bursts + 1;
         run_entry(tests[i]);
      end
      wait_ready();
      if (ar_count != exp_bursts) report_mismatch("ar_count", 32'(ar_count), 32'(exp_bursts));
      if (responses != NUM_TESTS) begin
         report_mismatch("responses", 32'(responses), 32'(NUM_TESTS));
      end

      $display("entries: %0d, responses: %0d, bursts: %0d, errors: %0d",
               NUM_TESTS, responses, ar_count, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Bounds the run if a handshake never comes
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the table did not complete", WATCHDOG_NS);
      $display("** FAIL **");
      $finish;
   end

endmodule

// File: filelist.f
common/icache_pkg.sv
design/icache_lookup/icache_lookup.sv
design/icache_refill/icache_refill.sv
design/icache_response/icache_data_ways.sv
design/icache_response/icache_response.sv
design/icache_top.sv
verification/axi_mem_model.sv
verification/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
